// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W      = 10;
    localparam int DATA_W      = 32;
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = ADDR_W - INDEX_W;
    localparam int LINES       = 16;
    localparam int WTB_DEPTH   = 4;
    localparam int WTB_PTR_W   = $clog2(WTB_DEPTH);
    localparam int CTRL_ADDR_W = 4;

    // Control register map. Unlisted addresses read zero.
    typedef enum logic [CTRL_ADDR_W-1:0] {
        CTRL_WTB_EMPTY    = 4'd1,
        CTRL_WTB_FULL     = 4'd2,
        CTRL_HITS         = 4'd3,
        CTRL_MISSES       = 4'd4,
        CTRL_READ_HITS    = 4'd5,
        CTRL_READ_MISSES  = 4'd6,
        CTRL_WRITE_HITS   = 4'd7,
        CTRL_WRITE_MISSES = 4'd8,
        CTRL_CNT_RESET    = 4'd9,
        CTRL_INVALIDATE   = 4'd10
    } ctrl_reg_e;

    typedef struct packed {
        logic              ctrl;  // Control register access.
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
    } fe_req_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } wtb_entry_t;

    typedef struct packed {
        logic read_hit;
        logic read_miss;
        logic write_hit;
        logic write_miss;
    } cache_event_t;

endpackage

`default_nettype wire

// File: hw/cache_lines.sv
`timescale 1ns/10ps
`default_nettype none

module cache_lines
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] lookup_addr,
    output logic              hit,
    output logic [DATA_W-1:0] line_data,
    input  logic              write_en,
    input  logic [ADDR_W-1:0] write_addr,
    input  logic [DATA_W-1:0] write_data,
    input  logic              invalidate
);

    logic [TAG_W-1:0]   tag_mem  [LINES];
    logic [DATA_W-1:0]  data_mem [LINES];
    logic [LINES-1:0]   valid;

    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   lookup_tag;
    logic [INDEX_W-1:0] write_index;
    logic [TAG_W-1:0]   write_tag;

    assign lookup_index = lookup_addr[INDEX_W-1:0];
    assign lookup_tag   = lookup_addr[ADDR_W-1:INDEX_W];
    assign write_index  = write_addr[INDEX_W-1:0];
    assign write_tag    = write_addr[ADDR_W-1:INDEX_W];

    // Direct-mapped lookup.
    assign hit       = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign line_data = data_mem[lookup_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else if (invalidate) begin
            valid <= '0;  // Drops every line at once.
        end else if (write_en) begin
            valid[write_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[write_index]  <= write_tag;
            data_mem[write_index] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/write_through_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module write_through_buffer
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  wtb_entry_t push_entry,
    input  logic       pop,
    output wtb_entry_t head,
    output logic       empty,
    output logic       full
);

    wtb_entry_t           entries [WTB_DEPTH];
    logic [WTB_PTR_W-1:0] wr_ptr;
    logic [WTB_PTR_W-1:0] rd_ptr;
    logic [WTB_PTR_W:0]   count;

    assign head  = entries[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == WTB_DEPTH[WTB_PTR_W:0]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps with the depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count as is.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_control.sv
`timescale 1ns/10ps
`default_nettype none

module cache_control
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ctrl_valid,
    input  ctrl_reg_e         ctrl_addr,
    input  cache_event_t      events,
    input  logic              wtb_empty,
    input  logic              wtb_full,
    output logic [DATA_W-1:0] ctrl_rdata,
    output logic              invalidate
);

    logic [DATA_W-1:0] read_hit_cnt;
    logic [DATA_W-1:0] read_miss_cnt;
    logic [DATA_W-1:0] write_hit_cnt;
    logic [DATA_W-1:0] write_miss_cnt;
    logic              cnt_clear;

    assign cnt_clear = ctrl_valid && (ctrl_addr == CTRL_CNT_RESET);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_hit_cnt   <= '0;
            read_miss_cnt  <= '0;
            write_hit_cnt  <= '0;
            write_miss_cnt <= '0;
            invalidate     <= 1'b0;
        end else begin
            invalidate <= ctrl_valid && (ctrl_addr == CTRL_INVALIDATE);  // One-cycle pulse.
            if (cnt_clear) begin
                read_hit_cnt   <= '0;
                read_miss_cnt  <= '0;
                write_hit_cnt  <= '0;
                write_miss_cnt <= '0;
            end else begin
                // Counters wrap silently.
                if (events.read_hit)   read_hit_cnt   <= read_hit_cnt + 1'b1;
                if (events.read_miss)  read_miss_cnt  <= read_miss_cnt + 1'b1;
                if (events.write_hit)  write_hit_cnt  <= write_hit_cnt + 1'b1;
                if (events.write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
            end
        end
    end

    // Register read, valid in the cycle after the access.
    always_ff @(posedge clk) begin
        ctrl_rdata <= '0;
        if (ctrl_valid) begin
            case (ctrl_addr)
                CTRL_WTB_EMPTY:    ctrl_rdata <= {{(DATA_W-1){1'b0}}, wtb_empty};
                CTRL_WTB_FULL:     ctrl_rdata <= {{(DATA_W-1){1'b0}}, wtb_full};
                CTRL_HITS:         ctrl_rdata <= read_hit_cnt + write_hit_cnt;
                CTRL_MISSES:       ctrl_rdata <= read_miss_cnt + write_miss_cnt;
                CTRL_READ_HITS:    ctrl_rdata <= read_hit_cnt;
                CTRL_READ_MISSES:  ctrl_rdata <= read_miss_cnt;
                CTRL_WRITE_HITS:   ctrl_rdata <= write_hit_cnt;
                CTRL_WRITE_MISSES: ctrl_rdata <= write_miss_cnt;
                default:           ctrl_rdata <= '0;  // Commands read zero.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_front.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_front
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  fe_req_t           req,
    output logic [DATA_W-1:0] rdata,
    output logic              ready,
    output logic [ADDR_W-1:0] lookup_addr,
    input  logic              hit,
    input  logic [DATA_W-1:0] line_data,
    output logic              fill_en,
    output logic [ADDR_W-1:0] fill_addr,
    output logic [DATA_W-1:0] fill_data,
    output logic              wtb_push,
    output wtb_entry_t        wtb_entry,
    output logic              wtb_pop,
    input  wtb_entry_t        wtb_head,
    input  logic              wtb_empty,
    input  logic              wtb_full,
    output cache_event_t      events,
    output logic              ctrl_valid,
    output ctrl_reg_e         ctrl_addr,
    input  logic [DATA_W-1:0] ctrl_rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        CTRL_WAIT,
        WRITE_WAIT,
        MISS_DRAIN,
        MISS_FETCH,
        RESPOND
    } state_e;

    state_e            state;
    fe_req_t           req_q;
    logic [DATA_W-1:0] rdata_q;
    logic              mem_busy;     // One request outstanding on the memory port.
    logic              cache_req;
    logic              read_issue;
    logic              drain_issue;

    assign cache_req   = (state == IDLE) && req_valid && !req.ctrl;
    assign lookup_addr = req.addr;
    assign ctrl_valid  = (state == IDLE) && req_valid && req.ctrl;
    assign ctrl_addr   = ctrl_reg_e'(req.addr[CTRL_ADDR_W-1:0]);

    // Write hits update the line at once. Read misses fill on mem_ack.
    always_comb begin
        fill_en   = cache_req && req.we && hit;
        fill_addr = req.addr;
        fill_data = req.wdata;
        if ((state == MISS_FETCH) && mem_ack) begin
            fill_en   = 1'b1;
            fill_addr = req_q.addr;
            fill_data = mem_rdata;
        end
    end

    assign wtb_push = (cache_req && req.we && !wtb_full) || ((state == WRITE_WAIT) && !wtb_full);

    always_comb begin
        wtb_entry.addr  = req.addr;
        wtb_entry.wdata = req.wdata;
        if (state == WRITE_WAIT) begin
            wtb_entry.addr  = req_q.addr;
            wtb_entry.wdata = req_q.wdata;
        end
    end

    // A miss fetch goes out only once every buffered write has landed.
    assign read_issue  = (state == MISS_DRAIN) && wtb_empty && !mem_busy;
    assign drain_issue = !mem_busy && !wtb_empty && (state != MISS_FETCH);
    assign mem_valid   = read_issue || drain_issue;
    assign wtb_pop     = mem_ack && (state != MISS_FETCH);  // Ack of a drain write.

    always_comb begin
        mem_req.we    = 1'b1;
        mem_req.addr  = wtb_head.addr;
        mem_req.wdata = wtb_head.wdata;
        if (read_issue) begin
            mem_req.we    = 1'b0;
            mem_req.addr  = req_q.addr;
            mem_req.wdata = '0;
        end
    end

    assign ready = (state == RESPOND) || (state == CTRL_WAIT);

    always_comb begin
        case (state)
            CTRL_WAIT: rdata = ctrl_rdata;
            RESPOND:   rdata = rdata_q;
            default:   rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            mem_busy <= 1'b0;
            events   <= '0;
        end else begin
            events <= '0;
            if (mem_valid) begin
                mem_busy <= 1'b1;
            end else if (mem_ack) begin
                mem_busy <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (ctrl_valid) begin
                        state <= CTRL_WAIT;
                    end else if (cache_req && req.we) begin
                        events.write_hit  <= hit;
                        events.write_miss <= !hit;
                        state <= wtb_full ? WRITE_WAIT : RESPOND;
                    end else if (cache_req) begin
                        events.read_hit  <= hit;
                        events.read_miss <= !hit;
                        state <= hit ? RESPOND : MISS_DRAIN;
                    end
                end
                WRITE_WAIT: if (!wtb_full) state <= RESPOND;
                MISS_DRAIN: if (read_issue) state <= MISS_FETCH;
                MISS_FETCH: if (mem_ack) state <= RESPOND;
                default:    state <= IDLE;  // CTRL_WAIT and RESPOND last one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && req_valid) begin
            req_q <= req;
        end
        if (cache_req) begin
            rdata_q <= (!req.we && hit) ? line_data : '0;
        end else if ((state == MISS_FETCH) && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  fe_req_t           req,
    output logic [DATA_W-1:0] rdata,
    output logic              ready,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_rdata
);

    logic [ADDR_W-1:0] lookup_addr;
    logic              hit;
    logic [DATA_W-1:0] line_data;
    logic              fill_en;
    logic [ADDR_W-1:0] fill_addr;
    logic [DATA_W-1:0] fill_data;
    logic              wtb_push;
    wtb_entry_t        wtb_entry;
    logic              wtb_pop;
    wtb_entry_t        wtb_head;
    logic              wtb_empty;
    logic              wtb_full;
    cache_event_t      events;
    logic              ctrl_valid;
    ctrl_reg_e         ctrl_addr;
    logic [DATA_W-1:0] ctrl_rdata;
    logic              invalidate;

    dcache_front front_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .rdata      (rdata),
        .ready      (ready),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .line_data  (line_data),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .wtb_push   (wtb_push),
        .wtb_entry  (wtb_entry),
        .wtb_pop    (wtb_pop),
        .wtb_head   (wtb_head),
        .wtb_empty  (wtb_empty),
        .wtb_full   (wtb_full),
        .events     (events),
        .ctrl_valid (ctrl_valid),
        .ctrl_addr  (ctrl_addr),
        .ctrl_rdata (ctrl_rdata),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    cache_lines lines_i (
        .clk        (clk),
        .reset      (reset),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .line_data  (line_data),
        .write_en   (fill_en),
        .write_addr (fill_addr),
        .write_data (fill_data),
        .invalidate (invalidate)
    );

    write_through_buffer wtb_i (
        .clk       (clk),
        .reset     (reset),
        .push      (wtb_push),
        .push_entry(wtb_entry),
        .pop       (wtb_pop),
        .head      (wtb_head),
        .empty     (wtb_empty),
        .full      (wtb_full)
    );

    cache_control control_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl_valid(ctrl_valid),
        .ctrl_addr (ctrl_addr),
        .events    (events),
        .wtb_empty (wtb_empty),
        .wtb_full  (wtb_full),
        .ctrl_rdata(ctrl_rdata),
        .invalidate(invalidate)
    );

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              slow,       // Stretches every request by SLOW_EXTRA cycles.
    input  logic              mem_valid,
    input  mem_req_t          mem_req,
    output logic              mem_ack,
    output logic [DATA_W-1:0] mem_rdata
);

    localparam int SLOW_EXTRA = 10;

    logic [DATA_W-1:0] shadow [2**ADDR_W];
    logic [31:0]       rand_state;
    mem_req_t          pending_req;
    logic              pending;
    int                delay;
    int                i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (i = 0; i < 2**ADDR_W; i++) begin
            shadow[i] = i * 3;
        end
        rand_state = 32'd15272;
        pending    = 1'b0;
        delay      = 0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack   = 1'b0;
            mem_rdata = '0;
            if (reset) begin
                pending = 1'b0;
            end else if (pending) begin
                if (delay == 0) begin
                    mem_ack = 1'b1;
                    pending = 1'b0;
                    if (pending_req.we) begin
                        shadow[pending_req.addr] = pending_req.wdata;
                    end else begin
                        mem_rdata = shadow[pending_req.addr];
                    end
                end else begin
                    delay = delay - 1;
                end
            end
            // Requests are taken mid-cycle, where mem_valid is settled.
            @(negedge clk);
            if (!reset && mem_valid) begin
                pending_req = mem_req;
                pending     = 1'b1;
                rand_state  = xorshift32(rand_state);
                delay       = rand_state[1:0];  // Ack 1 to 4 cycles later.
                if (slow) begin
                    delay = delay + SLOW_EXTRA;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int READY_TIMEOUT = 200;
    localparam int POLL_LIMIT    = 100;
    localparam int MIX_COUNT     = 200;

    logic              clk;
    logic              reset;
    logic              req_valid;
    fe_req_t           req;
    logic [DATA_W-1:0] rdata;
    logic              ready;
    logic              mem_valid;
    mem_req_t          mem_req;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_rdata;
    logic              slow;

    // Reference model of the cache and the memory behind it.
    logic [TAG_W-1:0]  ref_tag [LINES];
    logic [LINES-1:0]  ref_valid;
    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    logic [DATA_W-1:0] cnt_read_hit;
    logic [DATA_W-1:0] cnt_read_miss;
    logic [DATA_W-1:0] cnt_write_hit;
    logic [DATA_W-1:0] cnt_write_miss;

    logic [DATA_W-1:0] expect_q [$];
    bit                compare_q [$];
    logic [DATA_W-1:0] mon_expected;
    bit                mon_compare;
    string             test_name;
    int                error_count;
    int                errors_at_start;
    int                tests_passed;
    int                tests_failed;
    logic [31:0]       rand_state;
    logic [DATA_W-1:0] resp;
    logic [ADDR_W-1:0] wr_addr [6];
    logic [DATA_W-1:0] wr_data [6];
    logic              mix_we;
    int                n;
    int                polls;

    dcache_top dcache_top_i (
        .clk      (clk),
        .reset    (reset),
        .req_valid(req_valid),
        .req      (req),
        .rdata    (rdata),
        .ready    (ready),
        .mem_valid(mem_valid),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata)
    );

    mem_model memory_i (
        .clk      (clk),
        .reset    (reset),
        .slow     (slow),
        .mem_valid(mem_valid),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected read data of one cache access; also tracks the hit and miss counts.
    function automatic logic [DATA_W-1:0] predict_access(input logic we,
                                                        input logic [ADDR_W-1:0] addr,
                                                        input logic [DATA_W-1:0] wdata);
        logic [INDEX_W-1:0] index;
        logic               resident;
        index    = addr[INDEX_W-1:0];
        resident = ref_valid[index] && (ref_tag[index] == addr[ADDR_W-1:INDEX_W]);
        if (we) begin
            ref_mem[addr] = wdata;  // No allocate on a write miss.
            if (resident) cnt_write_hit = cnt_write_hit + 1;
            else cnt_write_miss = cnt_write_miss + 1;
            return '0;
        end
        if (resident) begin
            cnt_read_hit = cnt_read_hit + 1;
        end else begin
            cnt_read_miss    = cnt_read_miss + 1;
            ref_tag[index]   = addr[ADDR_W-1:INDEX_W];
            ref_valid[index] = 1'b1;
        end
        return ref_mem[addr];
    endfunction

    function automatic logic [DATA_W-1:0] predict_register(input ctrl_reg_e r);
        case (r)
            CTRL_HITS:         return cnt_read_hit + cnt_write_hit;
            CTRL_MISSES:       return cnt_read_miss + cnt_write_miss;
            CTRL_READ_HITS:    return cnt_read_hit;
            CTRL_READ_MISSES:  return cnt_read_miss;
            CTRL_WRITE_HITS:   return cnt_write_hit;
            CTRL_WRITE_MISSES: return cnt_write_miss;
            CTRL_CNT_RESET: begin
                cnt_read_hit   = '0;
                cnt_read_miss  = '0;
                cnt_write_hit  = '0;
                cnt_write_miss = '0;
                return '0;
            end
            CTRL_INVALIDATE: begin
                ref_valid = '0;
                return '0;
            end
            default:           return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Run stopped: %s", reason);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic issue_request(input logic ctrl, input logic [ADDR_W-1:0] addr,
                                 input logic we, input logic [DATA_W-1:0] wdata,
                                 input logic [DATA_W-1:0] expected, input bit compare,
                                 output logic [DATA_W-1:0] response);
        int waited;
        expect_q.push_back(expected);
        compare_q.push_back(compare);
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.ctrl  = ctrl;
        req.addr  = addr;
        req.we    = we;
        req.wdata = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        waited    = 0;
        while (!ready && waited < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready) begin
            abort_run($sformatf("no ready strobe after %0d cycles in test %s",
                                READY_TIMEOUT, test_name));
        end else begin
            response = rdata;
            @(negedge clk);
            #1;  // The response checker has seen this strobe by now.
        end
    endtask

    task automatic cache_access(input logic we, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] response);
        logic [DATA_W-1:0] expected;
        expected = predict_access(we, addr, wdata);
        issue_request(1'b0, addr, we, wdata, expected, 1'b1, response);
    endtask

    task automatic reg_access(input ctrl_reg_e r, output logic [DATA_W-1:0] response);
        logic [DATA_W-1:0] expected;
        expected = predict_register(r);
        issue_request(1'b1, ADDR_W'(r), 1'b0, '0, expected, 1'b1, response);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // Response checker, one expected value per ready strobe.
    always @(negedge clk) begin
        if (!reset && ready) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("Ready strobe with no request pending in test %s", test_name);
            end else begin
                mon_expected = expect_q.pop_front();
                mon_compare  = compare_q.pop_front();
                if (mon_compare) check_value(test_name, mon_expected, rdata);
            end
        end
    end

    initial begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        slow           = 1'b0;
        ref_valid      = '0;
        cnt_read_hit   = '0;
        cnt_read_miss  = '0;
        cnt_write_hit  = '0;
        cnt_write_miss = '0;
        error_count    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rand_state     = 32'd15272;
        test_name      = "reset";
        for (n = 0; n < 2**ADDR_W; n++) begin
            ref_mem[n] = n * 3;  // Same preload as the memory model.
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("directed");
        cache_access(1'b0, 10'h025, '0, resp);
        cache_access(1'b0, 10'h025, '0, resp);
        cache_access(1'b1, 10'h025, 32'h1234_5678, resp);
        cache_access(1'b0, 10'h025, '0, resp);
        cache_access(1'b1, 10'h135, 32'hcafe_f00d, resp);  // Same index, other tag.
        cache_access(1'b0, 10'h135, '0, resp);
        end_test();

        start_test("random_mix");
        for (n = 0; n < MIX_COUNT; n++) begin
            rand_state = xorshift32(rand_state);
            mix_we     = rand_state[8];
            wr_addr[0] = {4'b0, rand_state[5:0]};  // Four tags per index.
            rand_state = xorshift32(rand_state);
            cache_access(mix_we, wr_addr[0], rand_state, resp);
        end
        end_test();

        start_test("counters");
        for (n = 3; n <= 8; n++) begin
            reg_access(ctrl_reg_e'(n[3:0]), resp);
        end
        reg_access(ctrl_reg_e'(4'd12), resp);
        end_test();

        start_test("reset_and_invalidate");
        reg_access(CTRL_CNT_RESET, resp);
        for (n = 3; n <= 8; n++) begin
            reg_access(ctrl_reg_e'(n[3:0]), resp);
        end
        cache_access(1'b0, 10'h2a7, '0, resp);
        cache_access(1'b0, 10'h2a7, '0, resp);
        reg_access(CTRL_INVALIDATE, resp);
        cache_access(1'b0, 10'h2a7, '0, resp);
        reg_access(CTRL_READ_MISSES, resp);
        check_value({test_name, " read misses"}, 32'd2, resp);
        reg_access(CTRL_READ_HITS, resp);
        end_test();

        start_test("buffer_backup");
        @(posedge clk);
        #1;
        slow = 1'b1;
        for (n = 0; n < 6; n++) begin
            rand_state = xorshift32(rand_state);
            wr_addr[n] = 10'h300 + n * 7;
            wr_data[n] = rand_state;
            cache_access(1'b1, wr_addr[n], wr_data[n], resp);
        end
        issue_request(1'b1, ADDR_W'(CTRL_WTB_FULL), 1'b0, '0, 32'd1, 1'b1, resp);
        polls = 0;
        resp  = '0;
        while (resp != 32'd1 && polls < POLL_LIMIT) begin
            issue_request(1'b1, ADDR_W'(CTRL_WTB_EMPTY), 1'b0, '0, '0, 1'b0, resp);
            polls++;
        end
        if (resp != 32'd1) begin
            abort_run($sformatf("write buffer still not empty after %0d polls", POLL_LIMIT));
        end else begin
            for (n = 0; n < 6; n++) begin
                check_value($sformatf("%s word %h", test_name, wr_addr[n]), wr_data[n],
                            memory_i.shadow[wr_addr[n]]);
            end
            slow = 1'b0;
            end_test();

            $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                     tests_passed, tests_failed, error_count);
            if (error_count == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
hw/dcache_pkg.sv
hw/cache_lines.sv
hw/write_through_buffer.sv
hw/cache_control.sv
hw/dcache_front.sv
hw/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv
